/* logic/esp_link_pkg.sv */
package esp_link_pkg;

  // command opcodes sent by the co-processor
  localparam logic [7:0] op_get_cookie       = 8'd0;
  localparam logic [7:0] op_get_version      = 8'd15;
  localparam logic [7:0] op_send_keyb        = 8'd19;
  localparam logic [7:0] op_set_led          = 8'd26;
  localparam logic [7:0] op_get_config       = 8'd27;
  localparam logic [7:0] op_set_spi_ctrl_reg = 8'd29;
  localparam logic [7:0] op_set_spi_data     = 8'd30;
  localparam logic [7:0] op_get_spi_data     = 8'd31;
  localparam logic [7:0] op_set_esp_status   = 8'd32;

  // fixed reply values
  localparam logic [7:0] cookie        = 8'hAF;
  localparam logic [2:0] version_major = 3'd0;
  localparam logic [4:0] version_minor = 5'd3;

  // configuration flash timing, in clk cycles
  localparam int         flash_bit_cycles  = 16;
  localparam logic [7:0] flash_xfer_cycles = 8'd128;

  // keyboard matrix depth
  localparam int keyb_rows = 8;

  typedef struct packed {
    logic [7:0] opcode;
    logic [7:0] p0;
    logic [7:0] p1;
  } cmd_action_t;

  typedef struct packed {
    logic red;
    logic green;
    logic blue;
  } led_t;

  // parameter bytes per opcode
  // bit 2 flags an unknown opcode, bits 1:0 hold the count
  function automatic logic [2:0] param_count(input logic [7:0] opcode);
    case (opcode)
      op_get_cookie,
      op_get_version,
      op_get_config,
      op_get_spi_data:     param_count = 3'd0;
      op_set_led,
      op_set_esp_status,
      op_set_spi_ctrl_reg,
      op_set_spi_data:     param_count = 3'd1;
      op_send_keyb:        param_count = 3'd2;
      default:             param_count = 3'b100;
    endcase
  endfunction

endpackage

/* logic/spi_byte_port.sv */
module spi_byte_port (
  input  logic       clk,
  input  logic       cass_out_sel_n,
  input  logic       sck,
  input  logic       cs_n,
  input  logic       mosi,
  input  logic       reply_valid,
  input  logic [7:0] reply_byte,
  output logic       byte_valid,
  output logic [7:0] rx_byte,
  output logic       miso
);

  logic [2:0] sck_q;
  logic [2:0] cs_n_q;
  logic [2:0] mosi_q;
  logic       sck_rise;
  logic       sck_fall;
  logic       cs_active;
  logic [2:0] bit_cnt;
  logic [7:0] tx_shift;
  logic       tx_step;

  // pin synchronizers, three flops each
  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      sck_q  <= '0;
      cs_n_q <= '1;
      mosi_q <= '0;
    end else begin
      sck_q  <= {sck_q[1:0], sck};
      cs_n_q <= {cs_n_q[1:0], cs_n};
      mosi_q <= {mosi_q[1:0], mosi};
    end
  end

  assign sck_rise  = (sck_q[2:1] == 2'b01);
  assign sck_fall  = (sck_q[2:1] == 2'b10);
  assign cs_active = ~cs_n_q[2];

  // bit counter, cleared while deselected
  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      bit_cnt    <= '0;
      byte_valid <= 1'b0;
    end else begin
      byte_valid <= 1'b0;
      if (!cs_active) begin
        bit_cnt <= '0;
      end else if (sck_rise) begin
        bit_cnt <= bit_cnt + 3'd1;
        if (bit_cnt == 3'd7) begin
          byte_valid <= 1'b1;
        end
      end
    end
  end

  // mosi sampled msb first
  always_ff @(posedge clk) begin
    if (cs_active && sck_rise) begin
      rx_byte <= {rx_byte[6:0], mosi_q[2]};
    end
  end

  // falling edges inside a byte move the next bit up;
  // the byte's closing rising edge drops the last one so the
  // trailing falling edge leaves a freshly loaded reply alone
  assign tx_step = cs_active &&
                   ((sck_fall && bit_cnt != 3'd0) || (sck_rise && bit_cnt == 3'd7));

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      tx_shift <= '0;
    end else if (reply_valid) begin
      tx_shift <= reply_byte;
    end else if (tx_step) begin
      tx_shift <= {tx_shift[6:0], 1'b0};
    end
  end

  // low while deselected
  assign miso = cs_active & tx_shift[7];

endmodule

/* logic/cmd_parser.sv */
module cmd_parser (
  input  logic                      clk,
  input  logic                      cass_out_sel_n,
  input  logic                      byte_valid,
  input  logic [7:0]                rx_byte,
  output logic                      act_valid,
  output esp_link_pkg::cmd_action_t act,
  output logic                      cmd_error
);

  typedef enum logic {
    st_idle,
    st_read_params
  } state_t;

  state_t     state;
  logic [1:0] params_left;
  logic       param_idx;
  logic [2:0] count_info;
  logic       op_unknown;
  logic [1:0] op_params;

  // lookup on the incoming byte, only meaningful in idle
  assign count_info = esp_link_pkg::param_count(rx_byte);
  assign op_unknown = count_info[2];
  assign op_params  = count_info[1:0];

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      state       <= st_idle;
      params_left <= '0;
      param_idx   <= 1'b0;
      act_valid   <= 1'b0;
      cmd_error   <= 1'b0;
    end else begin
      act_valid <= 1'b0;
      if (byte_valid) begin
        case (state)
          st_idle: begin
            param_idx <= 1'b0;
            if (op_unknown) begin
              // sticky until reset
              cmd_error <= 1'b1;
            end else if (op_params == 2'd0) begin
              act_valid <= 1'b1;
            end else begin
              params_left <= op_params;
              state       <= st_read_params;
            end
          end
          st_read_params: begin
            param_idx   <= 1'b1;
            params_left <= params_left - 2'd1;
            // last parameter byte fires the action
            if (params_left == 2'd1) begin
              act_valid <= 1'b1;
              state     <= st_idle;
            end
          end
          default: begin
            state <= st_idle;
          end
        endcase
      end
    end
  end

  // action fields fill in as the bytes arrive
  always_ff @(posedge clk) begin
    if (byte_valid) begin
      if (state == st_idle) begin
        act.opcode <= rx_byte;
      end else if (!param_idx) begin
        act.p0 <= rx_byte;
      end else begin
        act.p1 <= rx_byte;
      end
    end
  end

endmodule

/* logic/cmd_regs.sv */
module cmd_regs (
  input  logic                      clk,
  input  logic                      cass_out_sel_n,
  input  logic                      act_valid,
  input  esp_link_pkg::cmd_action_t act,
  input  logic [3:0]                conf,
  input  logic [7:0]                flash_rx,
  output logic                      reply_valid,
  output logic [7:0]                reply_byte,
  output esp_link_pkg::led_t        led,
  output logic [7:0]                esp_status,
  output logic                      keyb_pressed,
  output logic                      flash_cs_n,
  output logic                      flash_start,
  output logic [7:0]                flash_tx
);

  logic [7:0] keyb_matrix [esp_link_pkg::keyb_rows];
  // bit 7 of the flash control register, active high select
  logic       flash_sel;

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      led         <= '0;
      esp_status  <= '0;
      flash_sel   <= 1'b0;
      reply_valid <= 1'b0;
      flash_start <= 1'b0;
      for (int i = 0; i < esp_link_pkg::keyb_rows; i++) begin
        keyb_matrix[i] <= '0;
      end
    end else begin
      reply_valid <= 1'b0;
      flash_start <= 1'b0;
      if (act_valid) begin
        case (act.opcode)
          esp_link_pkg::op_set_led: begin
            led.red   <= act.p0[0];
            led.green <= act.p0[1];
            led.blue  <= act.p0[2];
          end
          esp_link_pkg::op_set_esp_status: begin
            esp_status <= act.p0;
          end
          esp_link_pkg::op_send_keyb: begin
            keyb_matrix[act.p0[2:0]] <= act.p1;
          end
          esp_link_pkg::op_set_spi_ctrl_reg: begin
            flash_sel <= act.p0[7];
          end
          esp_link_pkg::op_set_spi_data: begin
            flash_start <= 1'b1;
          end
          esp_link_pkg::op_get_cookie,
          esp_link_pkg::op_get_version,
          esp_link_pkg::op_get_config,
          esp_link_pkg::op_get_spi_data: begin
            reply_valid <= 1'b1;
          end
          default: begin
          end
        endcase
      end
    end
  end

  // reply and flash data, only read alongside their strobes
  always_ff @(posedge clk) begin
    if (act_valid) begin
      case (act.opcode)
        esp_link_pkg::op_get_cookie:   reply_byte <= esp_link_pkg::cookie;
        esp_link_pkg::op_get_version:  reply_byte <= {esp_link_pkg::version_major,
                                                      esp_link_pkg::version_minor};
        // switches read low when on
        esp_link_pkg::op_get_config:   reply_byte <= {4'b0000, ~conf};
        esp_link_pkg::op_get_spi_data: reply_byte <= flash_rx;
        esp_link_pkg::op_set_spi_data: flash_tx <= act.p0;
        default: begin
        end
      endcase
    end
  end

  // any key down in any row
  always_comb begin
    keyb_pressed = 1'b0;
    for (int i = 0; i < esp_link_pkg::keyb_rows; i++) begin
      keyb_pressed = keyb_pressed | (|keyb_matrix[i]);
    end
  end

  assign flash_cs_n = ~flash_sel;

endmodule

/* logic/flash_spi_master.sv */
module flash_spi_master (
  input  logic       clk,
  input  logic       cass_out_sel_n,
  input  logic       flash_start,
  input  logic [7:0] flash_tx,
  input  logic       flash_so,
  output logic [7:0] flash_rx,
  output logic       flash_busy,
  output logic       flash_sclk,
  output logic       flash_si
);

  logic [6:0] cnt;
  logic [3:0] phase;
  logic [7:0] shift_q;
  logic       si_q;
  logic       last_cycle;

  // position inside the current bit
  assign phase      = cnt[3:0];
  assign last_cycle = (cnt == 7'(esp_link_pkg::flash_xfer_cycles - 8'd1));

  // starts while busy are dropped
  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      flash_busy <= 1'b0;
      cnt        <= '0;
      si_q       <= 1'b0;
    end else if (!flash_busy) begin
      if (flash_start) begin
        flash_busy <= 1'b1;
        cnt        <= '0;
        si_q       <= flash_tx[7];
      end
    end else begin
      cnt <= cnt + 7'd1;
      if (last_cycle) begin
        flash_busy <= 1'b0;
        si_q       <= 1'b0;
      end else if (phase == 4'(esp_link_pkg::flash_bit_cycles - 1)) begin
        // next bit is on top after the mid-bit shift
        si_q <= shift_q[7];
      end
    end
  end

  // one register sends msb first and collects flash_so behind it
  always_ff @(posedge clk) begin
    if (!flash_busy && flash_start) begin
      shift_q <= flash_tx;
    end else if (flash_busy && phase == 4'(esp_link_pkg::flash_bit_cycles / 2)) begin
      shift_q <= {shift_q[6:0], flash_so};
    end
  end

  // clock high for the second half of each bit
  assign flash_sclk = flash_busy && (phase >= 4'(esp_link_pkg::flash_bit_cycles / 2));
  assign flash_si   = si_q;
  assign flash_rx   = shift_q;

endmodule

/* logic/esp_link_top.sv */
module esp_link_top (
  input  logic               clk,
  input  logic               cass_out_sel_n,
  input  logic               sck,
  input  logic               cs_n,
  input  logic               mosi,
  input  logic [3:0]         conf,
  input  logic               flash_so,
  output logic               miso,
  output esp_link_pkg::led_t led,
  output logic [7:0]         esp_status,
  output logic               keyb_pressed,
  output logic               cmd_error,
  output logic               flash_cs_n,
  output logic               flash_sclk,
  output logic               flash_si
);

  logic                      byte_valid;
  logic [7:0]                rx_byte;
  logic                      act_valid;
  esp_link_pkg::cmd_action_t act;
  logic                      reply_valid;
  logic [7:0]                reply_byte;
  logic                      flash_start;
  logic [7:0]                flash_tx;
  logic [7:0]                flash_rx;

  spi_byte_port u_spi_byte_port (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .sck            (sck),
    .cs_n           (cs_n),
    .mosi           (mosi),
    .reply_valid    (reply_valid),
    .reply_byte     (reply_byte),
    .byte_valid     (byte_valid),
    .rx_byte        (rx_byte),
    .miso           (miso)
  );

  cmd_parser u_cmd_parser (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .byte_valid     (byte_valid),
    .rx_byte        (rx_byte),
    .act_valid      (act_valid),
    .act            (act),
    .cmd_error      (cmd_error)
  );

  cmd_regs u_cmd_regs (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .act_valid      (act_valid),
    .act            (act),
    .conf           (conf),
    .flash_rx       (flash_rx),
    .reply_valid    (reply_valid),
    .reply_byte     (reply_byte),
    .led            (led),
    .esp_status     (esp_status),
    .keyb_pressed   (keyb_pressed),
    .flash_cs_n     (flash_cs_n),
    .flash_start    (flash_start),
    .flash_tx       (flash_tx)
  );

  // busy is handled inside the master, nothing upstream waits on it
  flash_spi_master u_flash_spi_master (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .flash_start    (flash_start),
    .flash_tx       (flash_tx),
    .flash_so       (flash_so),
    .flash_rx       (flash_rx),
    .flash_busy     (),
    .flash_sclk     (flash_sclk),
    .flash_si       (flash_si)
  );

endmodule

/* testbench/esp_link_checker.sv */
module esp_link_checker (
  input  logic               clk,
  input  logic               cass_out_sel_n,
  input  logic               sck,
  input  logic               cs_n,
  input  logic               miso,
  input  esp_link_pkg::led_t led,
  input  logic [7:0]         esp_status,
  input  logic               keyb_pressed,
  input  logic               cmd_error,
  input  logic               flash_cs_n,
  input  logic               flash_sclk,
  input  logic               flash_si,
  input  logic               check_now,
  input  logic [7:0]         exp_miso,
  input  esp_link_pkg::led_t exp_led,
  input  logic [7:0]         exp_esp_status,
  input  logic               exp_keyb_pressed,
  input  logic               exp_cmd_error,
  input  logic               exp_flash_cs_n,
  output int                 error_count,
  output int                 bytes_seen
);

  timeunit 1ns;
  timeprecision 100ps;

  logic       sck_d;
  logic [7:0] rx;
  int         bit_idx;

  task automatic compare(input string name, input logic [7:0] got, input logic [7:0] want);
    if (got !== want) begin
      error_count++;
      $display("[ERROR] %s: got 0x%02h, expected 0x%02h", name, got, want);
    end
  endtask

  // sck is seen one clk after its edge, when miso has long settled
  always @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      sck_d       <= 1'b0;
      bit_idx     <= 0;
      bytes_seen  <= 0;
      error_count = 0;
    end else begin
      sck_d <= sck;
      if (cs_n) begin
        bit_idx <= 0;
      end else if (sck && !sck_d) begin
        rx      <= {rx[6:0], miso};
        bit_idx <= (bit_idx + 1) % 8;
        // eighth bit closes the reply byte
        if (bit_idx == 7) begin
          compare("miso", {rx[6:0], miso}, exp_miso);
          bytes_seen <= bytes_seen + 1;
        end
      end
      if (check_now) begin
        compare("led", {5'd0, led}, {5'd0, exp_led});
        compare("esp_status", esp_status, exp_esp_status);
        compare("keyb_pressed", {7'd0, keyb_pressed}, {7'd0, exp_keyb_pressed});
        compare("cmd_error", {7'd0, cmd_error}, {7'd0, exp_cmd_error});
        compare("flash_cs_n", {7'd0, flash_cs_n}, {7'd0, exp_flash_cs_n});
        // flash master is idle at every check point
        compare("flash_sclk", {7'd0, flash_sclk}, 8'h00);
        compare("flash_si", {7'd0, flash_si}, 8'h00);
        compare("miso idle", {7'd0, miso}, 8'h00);
      end
    end
  end

endmodule

/* testbench/tb_esp_link.sv */
module tb_esp_link;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int          half_sck   = 8;
  localparam int          byte_gap   = 16;
  localparam int          wait_limit = 64;
  localparam logic [31:0] seed       = 32'heea842de;

  // outputs once an entry has finished
  typedef struct packed {
    esp_link_pkg::led_t led;
    logic [7:0]         esp_status;
    logic               keyb_pressed;
    logic               cmd_error;
    logic               flash_cs_n;
  } outputs_t;

  typedef struct packed {
    logic [1:0]      nbytes;
    logic [0:2][7:0] cmd;
    logic [7:0]      lead;
    logic [7:0]      reply;
    logic [7:0]      post_wait;
    outputs_t        outs;
  } entry_t;

  logic               clk, cass_out_sel_n, sck, cs_n, mosi, flash_so;
  logic [3:0]         conf;
  logic               miso, keyb_pressed, cmd_error, flash_cs_n, flash_sclk, flash_si;
  esp_link_pkg::led_t led, exp_led;
  logic [7:0]         esp_status, exp_esp_status, exp_miso, lead_reply;
  logic               check_now, exp_keyb_pressed, exp_cmd_error, exp_flash_cs_n;
  int                 error_count, bytes_seen, sent, timeouts;
  outputs_t           model;
  entry_t             table_q[$];

  // flash loopback
  assign flash_so = flash_si;

  esp_link_top u_dut (.*);
  esp_link_checker u_checker (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // mode 0, msb first
  task automatic send_byte(input logic [7:0] data, input logic [7:0] expected);
    @(posedge clk);
    exp_miso <= expected;
    for (int i = 7; i >= 0; i--) begin
      mosi <= data[i];
      repeat (half_sck) @(posedge clk);
      sck <= 1'b1;
      repeat (half_sck) @(posedge clk);
      sck <= 1'b0;
    end
    sent++;
    repeat (byte_gap) @(posedge clk);
  endtask

  task automatic wait_checked();
    int n;
    n = 0;
    while (bytes_seen != sent && n < wait_limit) begin
      @(posedge clk);
      n++;
    end
    if (bytes_seen != sent) begin
      timeouts++;
      $display("timeout: checker saw %0d of %0d bytes", bytes_seen, sent);
    end
  endtask

  task automatic check_outputs(input outputs_t outs);
    @(posedge clk);
    {exp_led, exp_esp_status, exp_keyb_pressed, exp_cmd_error, exp_flash_cs_n} <= outs;
    check_now <= 1'b1;
    @(posedge clk);
    check_now <= 1'b0;
  endtask

  task automatic add_entry(input int n, input logic [7:0] c0, input logic [7:0] c1,
                           input logic [7:0] c2, input logic [7:0] reply, input int post);
    entry_t e;
    e.nbytes    = 2'(n);
    e.cmd       = {c0, c1, c2};
    e.lead      = lead_reply;
    e.reply     = reply;
    e.post_wait = 8'(post);
    e.outs      = model;
    table_q.push_back(e);
    // the 00 readout byte is a get_cookie, so the next entry opens on AF
    lead_reply = 8'hAF;
  endtask

  task automatic run_entry(input entry_t e);
    @(posedge clk);
    cs_n <= 1'b0;
    for (int i = 0; i < int'(e.nbytes); i++) begin
      send_byte(e.cmd[i], (i == 0) ? e.lead : 8'h00);
    end
    send_byte(8'h00, e.reply);
    cs_n <= 1'b1;
    repeat (byte_gap) @(posedge clk);
    wait_checked();
    check_outputs(e.outs);
    repeat (int'(e.post_wait)) @(posedge clk);
  endtask

  task automatic build_table();
    logic [7:0] v;
    logic [7:0] row;
    lead_reply = 8'h00;
    add_entry(1, esp_link_pkg::op_get_cookie, 8'h00, 8'h00, 8'hAF, 0);
    add_entry(1, esp_link_pkg::op_get_version, 8'h00, 8'h00, 8'h03, 0);
    // switches read inverted
    add_entry(1, esp_link_pkg::op_get_config, 8'h00, 8'h00, {4'h0, ~conf}, 0);
    v = 8'($urandom);
    model.led = {v[0], v[1], v[2]};
    add_entry(2, esp_link_pkg::op_set_led, v, 8'h00, 8'h00, 0);
    v = 8'($urandom);
    model.esp_status = v;
    add_entry(2, esp_link_pkg::op_set_esp_status, v, 8'h00, 8'h00, 0);
    row = 8'($urandom_range(7, 0));
    v = 8'($urandom_range(255, 1));
    model.keyb_pressed = 1'b1;
    add_entry(3, esp_link_pkg::op_send_keyb, row, v, 8'h00, 0);
    model.keyb_pressed = 1'b0;
    add_entry(3, esp_link_pkg::op_send_keyb, row, 8'h00, 8'h00, 0);
    model.flash_cs_n = 1'b0;
    add_entry(2, esp_link_pkg::op_set_spi_ctrl_reg, 8'h80, 8'h00, 8'h00, 0);
    v = 8'($urandom);
    add_entry(2, esp_link_pkg::op_set_spi_data, v, 8'h00, 8'h00, 200);
    add_entry(1, esp_link_pkg::op_get_spi_data, 8'h00, 8'h00, v, 0);
    model.flash_cs_n = 1'b1;
    add_entry(2, esp_link_pkg::op_set_spi_ctrl_reg, 8'h00, 8'h00, 8'h00, 0);
    model.cmd_error = 1'b1;
    add_entry(1, 8'h99, 8'h00, 8'h00, 8'h00, 0);
    add_entry(1, esp_link_pkg::op_get_cookie, 8'h00, 8'h00, 8'hAF, 0);
    v = 8'($urandom);
    model.led = {v[0], v[1], v[2]};
    add_entry(2, esp_link_pkg::op_set_led, v, 8'h00, 8'h00, 0);
  endtask

  initial begin
    void'($urandom(seed));
    cass_out_sel_n = 1'b0;
    sck            = 1'b0;
    cs_n           = 1'b1;
    mosi           = 1'b0;
    conf           = 4'($urandom);
    exp_miso       = 8'h00;
    check_now      = 1'b0;
    sent           = 0;
    timeouts       = 0;
    model            = '0;
    model.flash_cs_n = 1'b1;
    {exp_led, exp_esp_status, exp_keyb_pressed, exp_cmd_error, exp_flash_cs_n} = model;
    repeat (2) @(posedge clk);
    cass_out_sel_n <= 1'b1;
    check_outputs(model);
    build_table();
    foreach (table_q[i]) begin
      run_entry(table_q[i]);
    end
    repeat (byte_gap) @(posedge clk);
    $display("errors: %0d mismatches, %0d timeouts", error_count, timeouts);
    if (error_count == 0 && timeouts == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* compile.f */
logic/esp_link_pkg.sv
logic/spi_byte_port.sv
logic/cmd_parser.sv
logic/cmd_regs.sv
logic/flash_spi_master.sv
logic/esp_link_top.sv
testbench/esp_link_checker.sv
testbench/tb_esp_link.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_esp_link
RTL_TOP  = esp_link_top
FILELIST = compile.f
OBJ_DIR  = obj_dir

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only --timing -f $(FILELIST) --top-module $(RTL_TOP)
	$(TOOL) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

sim:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$($(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf $(OBJ_DIR)
